// File: common/wbi_pkg.sv
// Wishbone interconnect package with bus types, memory map and staging states
package wbi_pkg;

  // Default number of bus masters
  parameter int NUM_MST = 3;

  // ------------------------------------------------------------------
  // Bus field types
  // ------------------------------------------------------------------
  typedef logic [31:0] wb_dat_t;
  typedef logic [31:0] wb_adr_t;
  typedef logic [3:0]  wb_sel_t;
  // Target slave id
  typedef logic [1:0]  tid_t;
  // Master index, also the grant
  typedef logic [1:0]  mst_id_t;
  // UART byte lane
  typedef logic [7:0]  byte_t;

  // ------------------------------------------------------------------
  // Memory map
  // ------------------------------------------------------------------
  localparam tid_t TID_FLASH = 2'd0;
  localparam tid_t TID_SDRAM = 2'd1;
  localparam tid_t TID_GLBL  = 2'd2;
  localparam tid_t TID_UART  = 2'd3;

  // Top nibble of the address
  localparam logic [3:0] REGION_FLASH = 4'h0;
  localparam logic [3:0] REGION_SPI   = 4'h1;
  localparam logic [3:0] REGION_SDRAM = 4'h2;

  // Upper 16 address bits of the register pages
  localparam logic [15:0] PAGE_GLBL = 16'h3000;
  localparam logic [15:0] PAGE_UART = 16'h3001;

  // Request from master toward slave, tid rides along with it
  typedef struct packed {
    wb_dat_t dat;
    wb_adr_t adr;
    wb_sel_t sel;
    logic    we;
    logic    cyc;
    logic    stb;
    tid_t    tid;
  } wb_req_t;

  // Response from slave back to master
  typedef struct packed {
    wb_dat_t dat;
    logic    ack;
  } wb_rsp_t;

  // Staging register states
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQ,
    ST_RSP
  } stage_state_e;

endpackage

// File: arbiter/wb_rr_arbiter.sv
// Round-robin bus arbiter, the grant stays with a master until its request drops
`timescale 1ns/100ps

module wb_rr_arbiter #(
  parameter int NUM_REQ = 3
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic [NUM_REQ-1:0]   req_i,
  output wbi_pkg::mst_id_t     gnt_o
);
  import wbi_pkg::*;

  mst_id_t gnt_q;
  mst_id_t gnt_d;
  // Current owner still wants the bus
  logic    own_req;

  assign own_req = req_i[gnt_q];

  // ------------------------------------------------------------------
  // Next grant
  // ------------------------------------------------------------------
  // Search downward from the farthest offset so that the
  // nearest requester after the owner wins last
  always_comb begin
    int idx;
    idx   = 0;
    gnt_d = gnt_q;
    if (!own_req) begin
      for (int ofs = NUM_REQ - 1; ofs > 0; ofs--) begin
        idx = (int'(gnt_q) + ofs) % NUM_REQ;
        if (req_i[idx]) begin
          gnt_d = mst_id_t'(idx);
        end
      end
    end
  end

  // Grant register, master 0 owns the bus out of reset
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      gnt_q <= '0;
    end else begin
      gnt_q <= gnt_d;
    end
  end

  assign gnt_o = gnt_q;

endmodule

// File: logic/wb_master_mux.sv
// Master side mux, decodes targets, forwards the granted request, routes the response
`timescale 1ns/100ps

module wb_master_mux #(
  parameter int NUM_MST = wbi_pkg::NUM_MST
) (
  input  wbi_pkg::wb_dat_t  m_dat_i [NUM_MST],
  input  wbi_pkg::wb_adr_t  m_adr_i [NUM_MST],
  input  wbi_pkg::wb_sel_t  m_sel_i [NUM_MST],
  input  logic              m_we_i  [NUM_MST],
  input  logic              m_cyc_i [NUM_MST],
  input  logic              m_stb_i [NUM_MST],
  input  wbi_pkg::mst_id_t  gnt_i,
  output wbi_pkg::wb_req_t  bus_req_o,
  input  wbi_pkg::wb_rsp_t  bus_rsp_i,
  output wbi_pkg::wb_dat_t  m_dat_o [NUM_MST],
  output logic              m_ack_o [NUM_MST]
);
  import wbi_pkg::*;

  // Per master request with its decoded target
  wb_req_t m_req [NUM_MST];

  // ------------------------------------------------------------------
  // Address decode
  // ------------------------------------------------------------------
  // Flash and SPI regions both land on slave 0
  // Unmapped space falls back to slave 0 as well
  function automatic tid_t decode_tid(input wb_adr_t adr);
    tid_t tid;
    if (adr[31:28] == REGION_FLASH || adr[31:28] == REGION_SPI) begin
      tid = TID_FLASH;
    end else if (adr[31:28] == REGION_SDRAM) begin
      tid = TID_SDRAM;
    end else if (adr[31:16] == PAGE_GLBL) begin
      tid = TID_GLBL;
    end else if (adr[31:16] == PAGE_UART) begin
      tid = TID_UART;
    end else begin
      tid = TID_FLASH;
    end
    return tid;
  endfunction

  // Pack each master's flat signals
  always_comb begin
    for (int i = 0; i < NUM_MST; i++) begin
      m_req[i].dat = m_dat_i[i];
      m_req[i].adr = m_adr_i[i];
      m_req[i].sel = m_sel_i[i];
      m_req[i].we  = m_we_i[i];
      m_req[i].cyc = m_cyc_i[i];
      m_req[i].stb = m_stb_i[i];
      m_req[i].tid = decode_tid(m_adr_i[i]);
    end
  end

  // Granted master drives the shared path
  assign bus_req_o = m_req[gnt_i];

  // Only the granted master sees data and ack
  always_comb begin
    for (int i = 0; i < NUM_MST; i++) begin
      m_dat_o[i] = (gnt_i == mst_id_t'(i)) ? bus_rsp_i.dat : '0;
      m_ack_o[i] = (gnt_i == mst_id_t'(i)) ? bus_rsp_i.ack : 1'b0;
    end
  end

endmodule

// File: logic/wb_stage.sv
// Staging register that breaks the request and response paths between masters and slaves
`timescale 1ns/100ps

module wb_stage (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  wbi_pkg::wb_req_t  up_req_i,
  output wbi_pkg::wb_rsp_t  up_rsp_o,
  output wbi_pkg::wb_req_t  dn_req_o,
  input  wbi_pkg::wb_rsp_t  dn_rsp_i
);
  import wbi_pkg::*;

  stage_state_e state_q;
  stage_state_e state_d;

  // Captured request and returned read data
  wb_req_t req_q;
  wb_dat_t rsp_dat_q;

  logic take_req;
  logic take_rsp;

  // New request accepted only from idle
  assign take_req = (state_q == ST_IDLE) && up_req_i.stb;
  // Slave completes the staged access
  assign take_rsp = (state_q == ST_REQ) && dn_rsp_i.ack;

  // ------------------------------------------------------------------
  // State machine
  // ------------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ST_IDLE: begin
        if (take_req) begin
          state_d = ST_REQ;
        end
      end
      // Slow slave simply keeps us here
      ST_REQ: begin
        if (take_rsp) begin
          state_d = ST_RSP;
        end
      end
      // One cycle of ack upstream, then free again
      ST_RSP: begin
        state_d = ST_IDLE;
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // ------------------------------------------------------------------
  // Payload registers
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (take_req) begin
      req_q <= up_req_i;
    end
    if (take_rsp) begin
      rsp_dat_q <= dn_rsp_i.dat;
    end
  end

  // Downstream strobes live only while in ST_REQ
  always_comb begin
    dn_req_o     = req_q;
    dn_req_o.cyc = req_q.cyc & (state_q == ST_REQ);
    dn_req_o.stb = req_q.stb & (state_q == ST_REQ);
  end

  // Upstream ack is a single cycle pulse in ST_RSP
  assign up_rsp_o.dat = rsp_dat_q;
  assign up_rsp_o.ack = (state_q == ST_RSP);

endmodule

// File: logic/wb_slave_demux.sv
// Slave side demux, steers the staged request by target id and picks the response
`timescale 1ns/100ps

module wb_slave_demux (
  input  wbi_pkg::wb_req_t  req_i,
  output wbi_pkg::wb_rsp_t  rsp_o,
  // Slave 0, flash
  output wbi_pkg::wb_dat_t  s0_dat_o,
  output wbi_pkg::wb_adr_t  s0_adr_o,
  output wbi_pkg::wb_sel_t  s0_sel_o,
  output logic              s0_we_o,
  output logic              s0_cyc_o,
  output logic              s0_stb_o,
  input  wbi_pkg::wb_dat_t  s0_dat_i,
  input  logic              s0_ack_i,
  // Slave 1, SDRAM
  output wbi_pkg::wb_dat_t  s1_dat_o,
  output wbi_pkg::wb_adr_t  s1_adr_o,
  output wbi_pkg::wb_sel_t  s1_sel_o,
  output logic              s1_we_o,
  output logic              s1_cyc_o,
  output logic              s1_stb_o,
  input  wbi_pkg::wb_dat_t  s1_dat_i,
  input  logic              s1_ack_i,
  // Slave 2, global registers with a short address
  output wbi_pkg::wb_dat_t  s2_dat_o,
  output wbi_pkg::byte_t    s2_adr_o,
  output wbi_pkg::wb_sel_t  s2_sel_o,
  output logic              s2_we_o,
  output logic              s2_cyc_o,
  output logic              s2_stb_o,
  input  wbi_pkg::wb_dat_t  s2_dat_i,
  input  logic              s2_ack_i,
  // Slave 3, UART byte port
  output wbi_pkg::byte_t    s3_dat_o,
  output wbi_pkg::byte_t    s3_adr_o,
  output logic              s3_sel_o,
  output logic              s3_we_o,
  output logic              s3_cyc_o,
  output logic              s3_stb_o,
  input  wbi_pkg::byte_t    s3_dat_i,
  input  logic              s3_ack_i
);
  import wbi_pkg::*;

  wb_req_t flash_req;
  wb_req_t sdram_req;
  wb_req_t glbl_req;
  wb_req_t uart_req;

  // Unselected slaves get an all zero request
  assign flash_req = (req_i.tid == TID_FLASH) ? req_i : '0;
  assign sdram_req = (req_i.tid == TID_SDRAM) ? req_i : '0;
  assign glbl_req  = (req_i.tid == TID_GLBL)  ? req_i : '0;
  assign uart_req  = (req_i.tid == TID_UART)  ? req_i : '0;

  // ------------------------------------------------------------------
  // Slave ports
  // ------------------------------------------------------------------
  assign s0_dat_o = flash_req.dat;
  assign s0_adr_o = flash_req.adr;
  assign s0_sel_o = flash_req.sel;
  assign s0_we_o  = flash_req.we;
  assign s0_cyc_o = flash_req.cyc;
  assign s0_stb_o = flash_req.stb;

  assign s1_dat_o = sdram_req.dat;
  assign s1_adr_o = sdram_req.adr;
  assign s1_sel_o = sdram_req.sel;
  assign s1_we_o  = sdram_req.we;
  assign s1_cyc_o = sdram_req.cyc;
  assign s1_stb_o = sdram_req.stb;

  // Register page decodes only the low address byte
  assign s2_dat_o = glbl_req.dat;
  assign s2_adr_o = glbl_req.adr[7:0];
  assign s2_sel_o = glbl_req.sel;
  assign s2_we_o  = glbl_req.we;
  assign s2_cyc_o = glbl_req.cyc;
  assign s2_stb_o = glbl_req.stb;

  // UART takes lane 0 only
  assign s3_dat_o = uart_req.dat[7:0];
  assign s3_adr_o = uart_req.adr[7:0];
  assign s3_sel_o = uart_req.sel[0];
  assign s3_we_o  = uart_req.we;
  assign s3_cyc_o = uart_req.cyc;
  assign s3_stb_o = uart_req.stb;

  // Response of the addressed slave
  always_comb begin
    unique case (req_i.tid)
      TID_SDRAM: rsp_o = '{dat: s1_dat_i, ack: s1_ack_i};
      TID_GLBL:  rsp_o = '{dat: s2_dat_i, ack: s2_ack_i};
      // Byte data zero-extended to the bus width
      TID_UART:  rsp_o = '{dat: {24'h0, s3_dat_i}, ack: s3_ack_i};
      default:   rsp_o = '{dat: s0_dat_i, ack: s0_ack_i};
    endcase
  end

endmodule

// File: logic/wb_interconnect.sv
// Wishbone interconnect top, three masters share one staged path to four slaves
`timescale 1ns/100ps

module wb_interconnect #(
  parameter int NUM_MST = wbi_pkg::NUM_MST
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  // Master 0, external host
  input  wbi_pkg::wb_dat_t  m0_dat_i,
  input  wbi_pkg::wb_adr_t  m0_adr_i,
  input  wbi_pkg::wb_sel_t  m0_sel_i,
  input  logic              m0_we_i,
  input  logic              m0_cyc_i,
  input  logic              m0_stb_i,
  output wbi_pkg::wb_dat_t  m0_dat_o,
  output logic              m0_ack_o,
  // Master 1, instruction port
  input  wbi_pkg::wb_dat_t  m1_dat_i,
  input  wbi_pkg::wb_adr_t  m1_adr_i,
  input  wbi_pkg::wb_sel_t  m1_sel_i,
  input  logic              m1_we_i,
  input  logic              m1_cyc_i,
  input  logic              m1_stb_i,
  output wbi_pkg::wb_dat_t  m1_dat_o,
  output logic              m1_ack_o,
  // Master 2, data port
  input  wbi_pkg::wb_dat_t  m2_dat_i,
  input  wbi_pkg::wb_adr_t  m2_adr_i,
  input  wbi_pkg::wb_sel_t  m2_sel_i,
  input  logic              m2_we_i,
  input  logic              m2_cyc_i,
  input  logic              m2_stb_i,
  output wbi_pkg::wb_dat_t  m2_dat_o,
  output logic              m2_ack_o,
  // Slave 0, flash
  output wbi_pkg::wb_dat_t  s0_dat_o,
  output wbi_pkg::wb_adr_t  s0_adr_o,
  output wbi_pkg::wb_sel_t  s0_sel_o,
  output logic              s0_we_o,
  output logic              s0_cyc_o,
  output logic              s0_stb_o,
  input  wbi_pkg::wb_dat_t  s0_dat_i,
  input  logic              s0_ack_i,
  // Slave 1, SDRAM
  output wbi_pkg::wb_dat_t  s1_dat_o,
  output wbi_pkg::wb_adr_t  s1_adr_o,
  output wbi_pkg::wb_sel_t  s1_sel_o,
  output logic              s1_we_o,
  output logic              s1_cyc_o,
  output logic              s1_stb_o,
  input  wbi_pkg::wb_dat_t  s1_dat_i,
  input  logic              s1_ack_i,
  // Slave 2, global registers
  output wbi_pkg::wb_dat_t  s2_dat_o,
  output wbi_pkg::byte_t    s2_adr_o,
  output wbi_pkg::wb_sel_t  s2_sel_o,
  output logic              s2_we_o,
  output logic              s2_cyc_o,
  output logic              s2_stb_o,
  input  wbi_pkg::wb_dat_t  s2_dat_i,
  input  logic              s2_ack_i,
  // Slave 3, UART
  output wbi_pkg::byte_t    s3_dat_o,
  output wbi_pkg::byte_t    s3_adr_o,
  output logic              s3_sel_o,
  output logic              s3_we_o,
  output logic              s3_cyc_o,
  output logic              s3_stb_o,
  input  wbi_pkg::byte_t    s3_dat_i,
  input  logic              s3_ack_i
);
  import wbi_pkg::*;

  // ------------------------------------------------------------------
  // Master side arrays
  // ------------------------------------------------------------------
  wb_dat_t m_wdat [NUM_MST];
  wb_adr_t m_adr  [NUM_MST];
  wb_sel_t m_sel  [NUM_MST];
  logic    m_we   [NUM_MST];
  logic    m_cyc  [NUM_MST];
  logic    m_stb  [NUM_MST];
  wb_dat_t m_rdat [NUM_MST];
  logic    m_ack  [NUM_MST];

  logic [NUM_MST-1:0] arb_req;
  mst_id_t            gnt;

  // Internal request and response paths
  wb_req_t mux_req;
  wb_rsp_t mux_rsp;
  wb_req_t stg_req;
  wb_rsp_t slv_rsp;

  assign m_wdat = '{m0_dat_i, m1_dat_i, m2_dat_i};
  assign m_adr  = '{m0_adr_i, m1_adr_i, m2_adr_i};
  assign m_sel  = '{m0_sel_i, m1_sel_i, m2_sel_i};
  assign m_we   = '{m0_we_i,  m1_we_i,  m2_we_i};
  assign m_cyc  = '{m0_cyc_i, m1_cyc_i, m2_cyc_i};
  assign m_stb  = '{m0_stb_i, m1_stb_i, m2_stb_i};

  assign m0_dat_o = m_rdat[0];
  assign m1_dat_o = m_rdat[1];
  assign m2_dat_o = m_rdat[2];
  assign m0_ack_o = m_ack[0];
  assign m1_ack_o = m_ack[1];
  assign m2_ack_o = m_ack[2];

  // Request drops in the ack cycle so the grant can move on
  for (genvar g = 0; g < NUM_MST; g++) begin : g_arb_req
    assign arb_req[g] = m_stb[g] & ~m_ack[g];
  end

  wb_rr_arbiter #(
    .NUM_REQ (NUM_MST)
  ) u_arb (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (arb_req),
    .gnt_o   (gnt)
  );

  wb_master_mux #(
    .NUM_MST (NUM_MST)
  ) u_mmux (
    .m_dat_i   (m_wdat),
    .m_adr_i   (m_adr),
    .m_sel_i   (m_sel),
    .m_we_i    (m_we),
    .m_cyc_i   (m_cyc),
    .m_stb_i   (m_stb),
    .gnt_i     (gnt),
    .bus_req_o (mux_req),
    .bus_rsp_i (mux_rsp),
    .m_dat_o   (m_rdat),
    .m_ack_o   (m_ack)
  );

  wb_stage u_stage (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .up_req_i (mux_req),
    .up_rsp_o (mux_rsp),
    .dn_req_o (stg_req),
    .dn_rsp_i (slv_rsp)
  );

  wb_slave_demux u_sdemux (
    .req_i    (stg_req),
    .rsp_o    (slv_rsp),
    .s0_dat_o (s0_dat_o),
    .s0_adr_o (s0_adr_o),
    .s0_sel_o (s0_sel_o),
    .s0_we_o  (s0_we_o),
    .s0_cyc_o (s0_cyc_o),
    .s0_stb_o (s0_stb_o),
    .s0_dat_i (s0_dat_i),
    .s0_ack_i (s0_ack_i),
    .s1_dat_o (s1_dat_o),
    .s1_adr_o (s1_adr_o),
    .s1_sel_o (s1_sel_o),
    .s1_we_o  (s1_we_o),
    .s1_cyc_o (s1_cyc_o),
    .s1_stb_o (s1_stb_o),
    .s1_dat_i (s1_dat_i),
    .s1_ack_i (s1_ack_i),
    .s2_dat_o (s2_dat_o),
    .s2_adr_o (s2_adr_o),
    .s2_sel_o (s2_sel_o),
    .s2_we_o  (s2_we_o),
    .s2_cyc_o (s2_cyc_o),
    .s2_stb_o (s2_stb_o),
    .s2_dat_i (s2_dat_i),
    .s2_ack_i (s2_ack_i),
    .s3_dat_o (s3_dat_o),
    .s3_adr_o (s3_adr_o),
    .s3_sel_o (s3_sel_o),
    .s3_we_o  (s3_we_o),
    .s3_cyc_o (s3_cyc_o),
    .s3_stb_o (s3_stb_o),
    .s3_dat_i (s3_dat_i),
    .s3_ack_i (s3_ack_i)
  );

endmodule

// File: sim/wb_slave_model.sv
// Behavioral Wishbone slave with a small word memory, a one cycle ack and an access counter
`timescale 1ns/100ps

module wb_slave_model #(
  parameter int          SLV_ID    = 0,
  parameter logic [31:0] ADR_MASK  = 32'h0000_0000,
  parameter logic [31:0] ADR_MATCH = 32'h0000_0000
) (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        cyc_i,
  input  logic        stb_i,
  input  logic        we_i,
  input  logic [31:0] adr_i,
  input  logic [31:0] dat_i,
  input  logic [3:0]  sel_i,
  output logic [31:0] dat_o,
  output logic        ack_o,
  output logic [15:0] hits_o,
  output logic        bad_o
);

  // Sixteen words, indexed by the word address
  logic [31:0] mem [16];
  logic [3:0]  idx;
  // New access seen, ack not yet given
  logic        start;

  assign idx   = adr_i[5:2];
  assign start = cyc_i & stb_i & ~ack_o;

  // Power-on contents, unique per slave and per word
  function automatic logic [31:0] fill_word(input int i);
    return (32'(SLV_ID) << 28) ^ (32'(i) * 32'h0001_0203) ^ 32'h5A5A_0000;
  endfunction

  // ------------------------------------------------------------------
  // Access handling
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ack_o  <= 1'b0;
      dat_o  <= '0;
      hits_o <= '0;
      bad_o  <= 1'b0;
      for (int i = 0; i < 16; i++) begin
        mem[i] <= fill_word(i);
      end
    end else begin
      // Ack follows stb by one cycle and lasts one cycle
      ack_o <= start;
      if (start) begin
        hits_o <= hits_o + 16'd1;
        dat_o  <= mem[idx];
        if (we_i) begin
          for (int b = 0; b < 4; b++) begin
            if (sel_i[b]) begin
              mem[idx][8*b +: 8] <= dat_i[8*b +: 8];
            end
          end
        end
        // Sticky flag for an address this slave does not own
        if ((adr_i & ADR_MASK) != ADR_MATCH) begin
          bad_o <= 1'b1;
        end
      end
    end
  end

endmodule

// File: sim/tb_wb_interconnect.sv
// Testbench for the Wishbone interconnect with pattern driven masters and four slave models
`timescale 1ns/100ps

module tb_wb_interconnect;
  import wbi_pkg::*;

  // Six words per transaction in the pattern file
  localparam int PAT_WORDS = 6 * 32;
  // Round robin transactions run ahead of the patterns
  localparam int RR_TXN    = 6;

  logic clk   = 1'b0;
  logic rst_n = 1'b0;

  // Master side
  wb_dat_t m_dat  [3];
  wb_adr_t m_adr  [3];
  wb_sel_t m_sel  [3];
  logic    m_we   [3];
  logic    m_cyc  [3];
  logic    m_stb  [3];
  wb_dat_t m_rdat [3];
  logic    m_ack  [3];

  // Slave side with narrow fields on slaves 2 and 3
  wb_dat_t     s_wdat [3];
  byte_t       s3_wdat;
  wb_adr_t     s_adr  [2];
  byte_t       s2_adr;
  byte_t       s3_adr;
  wb_sel_t     s_sel  [3];
  logic        s3_sel;
  logic        s_we   [4];
  logic        s_cyc  [4];
  logic        s_stb  [4];
  wb_dat_t     s_rdat [4];
  logic        s_ack  [4];
  logic [15:0] s_hits [4];
  logic        s_bad  [4];

  logic [31:0] pat [PAT_WORDS];
  int          n_pat = 0;
  int          ack_order [$];
  wb_dat_t     rr_dat [3];

  // Monitor history
  int   cyc_cnt = 0;
  logic rst_d   = 1'b0;
  logic sack_d  = 1'b0;
  logic stb_d   [3];

  always #50 clk = ~clk;

  wb_interconnect DUT (
    .clk_i (clk), .rst_n_i (rst_n),
    .m0_dat_i (m_dat[0]), .m0_adr_i (m_adr[0]), .m0_sel_i (m_sel[0]), .m0_we_i (m_we[0]),
    .m0_cyc_i (m_cyc[0]), .m0_stb_i (m_stb[0]), .m0_dat_o (m_rdat[0]), .m0_ack_o (m_ack[0]),
    .m1_dat_i (m_dat[1]), .m1_adr_i (m_adr[1]), .m1_sel_i (m_sel[1]), .m1_we_i (m_we[1]),
    .m1_cyc_i (m_cyc[1]), .m1_stb_i (m_stb[1]), .m1_dat_o (m_rdat[1]), .m1_ack_o (m_ack[1]),
    .m2_dat_i (m_dat[2]), .m2_adr_i (m_adr[2]), .m2_sel_i (m_sel[2]), .m2_we_i (m_we[2]),
    .m2_cyc_i (m_cyc[2]), .m2_stb_i (m_stb[2]), .m2_dat_o (m_rdat[2]), .m2_ack_o (m_ack[2]),
    .s0_dat_o (s_wdat[0]), .s0_adr_o (s_adr[0]), .s0_sel_o (s_sel[0]), .s0_we_o (s_we[0]),
    .s0_cyc_o (s_cyc[0]), .s0_stb_o (s_stb[0]), .s0_dat_i (s_rdat[0]), .s0_ack_i (s_ack[0]),
    .s1_dat_o (s_wdat[1]), .s1_adr_o (s_adr[1]), .s1_sel_o (s_sel[1]), .s1_we_o (s_we[1]),
    .s1_cyc_o (s_cyc[1]), .s1_stb_o (s_stb[1]), .s1_dat_i (s_rdat[1]), .s1_ack_i (s_ack[1]),
    .s2_dat_o (s_wdat[2]), .s2_adr_o (s2_adr), .s2_sel_o (s_sel[2]), .s2_we_o (s_we[2]),
    .s2_cyc_o (s_cyc[2]), .s2_stb_o (s_stb[2]), .s2_dat_i (s_rdat[2]), .s2_ack_i (s_ack[2]),
    .s3_dat_o (s3_wdat), .s3_adr_o (s3_adr), .s3_sel_o (s3_sel), .s3_we_o (s_we[3]),
    .s3_cyc_o (s_cyc[3]), .s3_stb_o (s_stb[3]), .s3_dat_i (s_rdat[3][7:0]), .s3_ack_i (s_ack[3])
  );

  // ------------------------------------------------------------------
  // Slave models
  // ------------------------------------------------------------------
  // Flash also catches unmapped space, so no region limit
  wb_slave_model #(.SLV_ID (0)) u_slv0 (
    .clk_i (clk), .rst_n_i (rst_n), .cyc_i (s_cyc[0]), .stb_i (s_stb[0]), .we_i (s_we[0]),
    .adr_i (s_adr[0]), .dat_i (s_wdat[0]), .sel_i (s_sel[0]),
    .dat_o (s_rdat[0]), .ack_o (s_ack[0]), .hits_o (s_hits[0]), .bad_o (s_bad[0])
  );
  wb_slave_model #(.SLV_ID (1), .ADR_MASK (32'hF000_0000), .ADR_MATCH (32'h2000_0000)) u_slv1 (
    .clk_i (clk), .rst_n_i (rst_n), .cyc_i (s_cyc[1]), .stb_i (s_stb[1]), .we_i (s_we[1]),
    .adr_i (s_adr[1]), .dat_i (s_wdat[1]), .sel_i (s_sel[1]),
    .dat_o (s_rdat[1]), .ack_o (s_ack[1]), .hits_o (s_hits[1]), .bad_o (s_bad[1])
  );
  // Register pages and the UART see a byte address only, so their whole space is in region
  wb_slave_model #(.SLV_ID (2)) u_slv2 (
    .clk_i (clk), .rst_n_i (rst_n), .cyc_i (s_cyc[2]), .stb_i (s_stb[2]), .we_i (s_we[2]),
    .adr_i ({24'h0, s2_adr}), .dat_i (s_wdat[2]), .sel_i (s_sel[2]),
    .dat_o (s_rdat[2]), .ack_o (s_ack[2]), .hits_o (s_hits[2]), .bad_o (s_bad[2])
  );
  wb_slave_model #(.SLV_ID (3)) u_slv3 (
    .clk_i (clk), .rst_n_i (rst_n), .cyc_i (s_cyc[3]), .stb_i (s_stb[3]), .we_i (s_we[3]),
    .adr_i ({24'h0, s3_adr}), .dat_i ({24'h0, s3_wdat}), .sel_i ({3'b0, s3_sel}),
    .dat_o (s_rdat[3]), .ack_o (s_ack[3]), .hits_o (s_hits[3]), .bad_o (s_bad[3])
  );

  // ------------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------------
  task automatic abort_run();
    $display("TEST FAIL");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic check_equal(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("** Error: %s: expected %08h, actual %08h", name, exp, act);
      abort_run();
    end
  endtask

  // Slave index from the reference memory map
  function automatic int slave_for_addr(input logic [31:0] adr);
    if (adr[31:28] == 4'h0 || adr[31:28] == 4'h1) begin
      return 0;
    end
    if (adr[31:28] == 4'h2) begin
      return 1;
    end
    if (adr[31:16] == 16'h3000) begin
      return 2;
    end
    if (adr[31:16] == 16'h3001) begin
      return 3;
    end
    return 0;
  endfunction

  // One classic cycle held until ack and dropped on the same falling edge
  task automatic run_txn(input int m, input logic we, input wb_adr_t adr, input wb_dat_t wdat,
                         input wb_sel_t sel, output wb_dat_t rdat);
    @(negedge clk);
    m_adr[m] = adr;
    m_dat[m] = wdat;
    m_sel[m] = sel;
    m_we[m]  = we;
    m_cyc[m] = 1'b1;
    m_stb[m] = 1'b1;
    @(negedge clk);
    while (m_ack[m] !== 1'b1) begin
      @(negedge clk);
    end
    rdat = m_rdat[m];
    ack_order.push_back(m);
    m_cyc[m] = 1'b0;
    m_stb[m] = 1'b0;
    m_we[m]  = 1'b0;
  endtask

  // ------------------------------------------------------------------
  // Bus monitor sampling the settled values of the cycle just ended
  // ------------------------------------------------------------------
  always @(posedge clk) begin : bus_monitor
    int   n_ack;
    logic sack_now;
    n_ack    = 0;
    sack_now = 1'b0;
    if (cyc_cnt > 0) begin
      for (int s = 0; s < 4; s++) begin
        if (s_bad[s] === 1'b1) begin
          $display("Slave %0d received an access outside its address region", s);
          abort_run();
        end
        // Quiet bus during reset and the first cycle out of it
        if (!rst_n || !rst_d) begin
          check_equal($sformatf("reset slave %0d cyc/stb", s), 32'd0,
                      32'({s_cyc[s], s_stb[s]}));
        end
        if (s_ack[s] === 1'b1) begin
          sack_now = 1'b1;
        end
      end
      for (int m = 0; m < 3; m++) begin
        if (!rst_n || !rst_d) begin
          check_equal($sformatf("reset master %0d ack", m), 32'd0, 32'(m_ack[m]));
        end
        if (m_ack[m] === 1'b1) begin
          n_ack++;
          // Only a master that was requesting may see ack
          check_equal($sformatf("master %0d ack without request", m), 32'd1, 32'(stb_d[m]));
        end
      end
      // At most one master is acked in any cycle
      if (n_ack > 1) begin
        check_equal("master acks in one cycle", 32'd1, 32'(n_ack));
      end
      check_equal("master ack one cycle after slave ack", 32'(sack_d), 32'(n_ack > 0));
    end
    for (int m = 0; m < 3; m++) begin
      stb_d[m] = m_stb[m];
    end
    sack_d  = sack_now;
    rst_d   = rst_n;
    cyc_cnt = cyc_cnt + 1;
  end

  // Run limit scales with the number of transactions
  initial begin : watchdog
    wait (n_pat > 0);
    repeat ((n_pat + RR_TXN + 1) * 40) @(posedge clk);
    $display("Timeout: the transactions did not finish in time");
    abort_run();
  end

  // ------------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------------
  initial begin : main_seq
    wb_dat_t     rdat;
    int          base;
    int          exp_slv;
    int          cnt;
    logic [15:0] hits_before [4];
    void'($urandom(32'he08e2700));
    for (int m = 0; m < 3; m++) begin
      m_dat[m] = '0;
      m_adr[m] = '0;
      m_sel[m] = '0;
      m_we[m]  = 1'b0;
      m_cyc[m] = 1'b0;
      m_stb[m] = 1'b0;
      stb_d[m] = 1'b0;
    end
    for (int i = 0; i < PAT_WORDS; i++) begin
      pat[i] = '1;
    end
    $readmemh("sim/wb_patterns.txt", pat);
    // All ones in the master column marks the end of the list
    cnt = 0;
    while (cnt * 6 < PAT_WORDS && pat[cnt * 6] !== 32'hFFFF_FFFF) begin
      cnt++;
    end
    n_pat = cnt;
    if (n_pat == 0) begin
      $display("No transactions found in sim/wb_patterns.txt");
      abort_run();
    end
    // Requests raised while reset is held must not reach any slave
    repeat (2) @(negedge clk);
    for (int m = 0; m < 3; m++) begin
      m_adr[m] = 32'h2000_0020;
      m_cyc[m] = 1'b1;
      m_stb[m] = 1'b1;
    end
    repeat (3) @(negedge clk);
    for (int m = 0; m < 3; m++) begin
      m_cyc[m] = 1'b0;
      m_stb[m] = 1'b0;
    end
    rst_n = 1'b1;
    repeat (2) @(negedge clk);

    // Three masters at once with the grant starting at m0
    fork
      run_txn(0, 1'b1, 32'h2000_0020, 32'h0000_00A0, 4'hF, rr_dat[0]);
      run_txn(1, 1'b1, 32'h2000_0024, 32'h0000_00A1, 4'hF, rr_dat[1]);
      run_txn(2, 1'b1, 32'h2000_0028, 32'h0000_00A2, 4'hF, rr_dat[2]);
    join
    check_equal("round robin ack count", 32'd3, 32'(ack_order.size()));
    for (int i = 0; i < 3; i++) begin
      check_equal($sformatf("round robin ack %0d", i), 32'(i), 32'(ack_order[i]));
    end
    ack_order.delete();
    // With m1 served last m2 comes before m0
    run_txn(1, 1'b0, 32'h2000_0024, '0, 4'hF, rdat);
    check_equal("round robin m1 read", 32'h0000_00A1, rdat);
    fork
      run_txn(0, 1'b0, 32'h2000_0020, '0, 4'hF, rr_dat[0]);
      run_txn(2, 1'b0, 32'h2000_0028, '0, 4'hF, rr_dat[2]);
    join
    check_equal("round robin second ack", 32'd2, 32'(ack_order[1]));
    check_equal("round robin third ack", 32'd0, 32'(ack_order[2]));
    check_equal("round robin m0 read", 32'h0000_00A0, rr_dat[0]);
    check_equal("round robin m2 read", 32'h0000_00A2, rr_dat[2]);

    // Pattern transactions one at a time with random idle gaps
    for (int i = 0; i < n_pat; i++) begin
      base    = i * 6;
      exp_slv = slave_for_addr(pat[base + 2]);
      hits_before = s_hits;
      repeat ($urandom % 4) @(negedge clk);
      run_txn(int'(pat[base]), pat[base + 1][0], pat[base + 2], pat[base + 3],
              pat[base + 4][3:0], rdat);
      for (int s = 0; s < 4; s++) begin
        check_equal($sformatf("pattern %0d slave %0d accesses", i, s),
                    32'(hits_before[s]) + ((s == exp_slv) ? 32'd1 : 32'd0), 32'(s_hits[s]));
      end
      if (pat[base + 1][0] == 1'b0) begin
        check_equal($sformatf("pattern %0d read data", i), pat[base + 5], rdat);
      end
    end
    repeat (3) @(negedge clk);
    $display("TEST PASS");
    $finish;
  end

endmodule

// File: sim/wb_patterns.txt
// Columns: master  we  address  write_data  select  expected_read_data, all hex
// Reads ignore write_data and writes ignore expected_read_data
0 1 00000010 12345678 F 00000000
0 0 00000010 00000000 F 12345678
1 1 10000020 A5A50F0F F 00000000
1 0 10000020 00000000 F A5A50F0F
2 1 20000004 CAFEF00D F 00000000
2 0 20000004 00000000 F CAFEF00D
0 1 30000008 0BADC0DE F 00000000
0 0 30000008 00000000 F 0BADC0DE
1 1 30010004 DEADBE5A F 00000000
1 0 30010004 00000000 F 0000005A
2 1 40000030 76543210 F 00000000
2 0 40000030 00000000 F 76543210
0 1 20000008 11223344 F 00000000
0 1 20000008 AABBCCDD 3 00000000
0 0 20000008 00000000 F 1122CCDD
2 1 30010000 000000C3 1 00000000
2 0 30010000 00000000 F 000000C3
1 1 300000FC 89ABCDEF F 00000000
1 0 300000FC 00000000 F 89ABCDEF
0 1 F0000040 13579BDF F 00000000
0 0 F0000040 00000000 F 13579BDF
1 1 30020014 2468ACE0 F 00000000
1 0 30020014 00000000 F 2468ACE0

// File: wb_interconnect.f
common/wbi_pkg.sv
arbiter/wb_rr_arbiter.sv
logic/wb_master_mux.sv
logic/wb_stage.sv
logic/wb_slave_demux.sv
logic/wb_interconnect.sv
sim/wb_slave_model.sv
sim/tb_wb_interconnect.sv

// File: Makefile
# Verilator build and run of the Wishbone interconnect testbench

.PHONY: sim clean

# Pass is decided by the log, since the run is piped through tee
sim:
	verilator --binary --timing -j 0 --top-module tb_wb_interconnect \
	  -f wb_interconnect.f -Mdir obj_dir -o tb_wb_interconnect
	./obj_dir/tb_wb_interconnect | tee sim.log
	grep -q "TEST PASS" sim.log

clean:
	rm -rf obj_dir sim.log
